// File: fetch_pkg.sv
package fetch_pkg;

    // address and data widths of the fetch path
    localparam int PC_W     = 32;
    localparam int INST_W   = 32;
    localparam int EXCEP_W  = 16;   // one bit per exception cause

    // byte step between two sequential instructions
    localparam int INST_BYTES = 4;

    // words per fetch line
    // a pair is only fetched together when it stays inside one line
    localparam int LINE_WORDS = 4;

    // bit positions inside the exception vector
    localparam int INT_BIT  = 0;    // interrupt pending
    localparam int ADEF_BIT = 6;    // fetch address error

    // instruction address
    typedef logic [PC_W-1:0] pc_t;

    // one instruction word
    typedef logic [INST_W-1:0] inst_t;

    // exception cause vector carried with each line
    typedef logic [EXCEP_W-1:0] excep_t;

endpackage

// File: pre_if_stage.sv
`timescale 1ns/10ps

module pre_if_stage import fetch_pkg::*; #(
    parameter pc_t RESET_PC = '0       // first fetch address
) (
    input  logic clk,
    input  logic rst_i,

    // redirect from the back end
    input  logic flush_i,
    input  pc_t  flush_pc_i,

    // handshake with IF
    input  logic if_allowin_i,
    input  pc_t  next_base_i,          // last line IF is about to issue

    output logic pi_valid_o,
    output pc_t  pc1_o,
    output pc_t  pc2_o
);

    pc_t  pc_r;                        // address of line 1
    logic pi_valid_r;
    logic pi_ready_go;
    logic pi_to_if;                    // pair accepted by IF this cycle

    // address generation never stalls on its own
    assign pi_ready_go = 1'b1;
    assign pi_to_if    = pi_valid_r && pi_ready_go && if_allowin_i;

    // pc register
    // flush beats sequential advance
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_r <= RESET_PC;
        end else if (flush_i) begin
            pc_r <= flush_pc_i;        // new stream starts here
        end else if (pi_to_if) begin
            pc_r <= next_base_i + pc_t'(INST_BYTES);  // one word past last issued line
        end
    end

    // stage holds a fetch address from the first cycle out of reset
    // and keeps it through a flush, so only reset loads it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pi_valid_r <= 1'b1;
        end
    end

    assign pi_valid_o = pi_valid_r;
    assign pc1_o      = pc_r;
    assign pc2_o      = pc_r + pc_t'(INST_BYTES);  // line 2 always the next word

endmodule

// File: inst_mem.sv
`timescale 1ns/10ps

module inst_mem import fetch_pkg::*; #(
    parameter int unsigned MEM_WORDS = 32     // array depth in words
) (
    input  pc_t   pc_i,
    output inst_t inst1_o,
    output inst_t inst2_o,
    output logic  inst2_en_o
);

    localparam int IDX_W      = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int LINE_OFF_W = $clog2(LINE_WORDS);

    inst_t mem [MEM_WORDS];

    logic [PC_W-3:0]       word_addr;         // pc without byte offset
    logic [PC_W-3:0]       word_addr_nxt;
    logic [IDX_W-1:0]      idx1;
    logic [IDX_W-1:0]      idx2;
    logic [LINE_OFF_W-1:0] line_off;          // word slot inside the fetch line

    // image preloaded for simulation
    initial begin
        $readmemh("prog.hex", mem);
    end

    assign word_addr     = pc_i[PC_W-1:2];    // low two bits ignored
    assign word_addr_nxt = word_addr + 1'b1;

    // indices wrap around the array
    assign idx1 = IDX_W'(word_addr % MEM_WORDS);
    assign idx2 = IDX_W'(word_addr_nxt % MEM_WORDS);

    assign line_off = word_addr[LINE_OFF_W-1:0];

    // last slot of a line has no partner in the same line
    assign inst2_en_o = (line_off != LINE_OFF_W'(LINE_WORDS - 1));

    // async read
    assign inst1_o = mem[idx1];
    assign inst2_o = inst2_en_o ? mem[idx2] : '0;   // zero when line 2 misses

endmodule

// File: if_stage.sv
`timescale 1ns/10ps

module if_stage import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   flush_i,
    input  logic   int_i,            // interrupt request level

    // from pre-IF
    input  logic   pi_valid_i,
    input  pc_t    pc1_i,
    input  pc_t    pc2_i,
    output logic   if_allowin_o,

    // instruction memory lookup
    output pc_t    mem_pc_o,
    input  inst_t  inst1_i,
    input  inst_t  inst2_i,
    input  logic   inst2_en_i,

    // back to pre-IF
    output pc_t    next_base_o,

    // to the ID register
    input  logic   id_allowin_i,
    output logic   line1_valid_o,
    output logic   line2_valid_o,
    output pc_t    line1_pc_o,
    output pc_t    line2_pc_o,
    output inst_t  line1_inst_o,
    output inst_t  line2_inst_o,
    output logic   line1_excep_en_o,
    output logic   line2_excep_en_o,
    output excep_t line1_excep_o,
    output excep_t line2_excep_o
);

    logic   if_valid_r;
    logic   if_ready_go;
    logic   pi_to_if;                // new pair enters this stage

    pc_t    pc1_r;
    pc_t    pc2_r;
    inst_t  inst1_r;
    inst_t  inst2_r;
    logic   inst2_en_r;              // line 2 found in the same fetch line

    logic   line1_adef;
    logic   line2_adef;

    // lookup runs on the pair still sitting in pre-IF
    assign mem_pc_o = pc1_i;

    // pre-IF continues after pc2 only when line 2 goes out with it
    assign next_base_o = inst2_en_i ? pc2_i : pc1_i;

    // handshake
    assign if_ready_go  = 1'b1;                  // data is ready the cycle it lands
    assign if_allowin_o = !if_valid_r            // empty stage
                        || (if_ready_go && id_allowin_i);  // or packet leaves now
    assign pi_to_if     = pi_valid_i && if_allowin_o;

    // stage valid
    // flush kills whatever was fetched
    always_ff @(posedge clk) begin
        if (rst_i) begin
            if_valid_r <= 1'b0;
        end else if (flush_i) begin
            if_valid_r <= 1'b0;
        end else if (if_allowin_o) begin
            if_valid_r <= pi_valid_i;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (pi_to_if) begin
            pc1_r      <= pc1_i;
            pc2_r      <= pc2_i;
            inst1_r    <= inst1_i;
            inst2_r    <= inst2_i;
            inst2_en_r <= inst2_en_i;
        end
    end

    // fetch address error on unaligned pc
    assign line1_adef = (pc1_r[1:0] != 2'b00);
    assign line2_adef = (pc2_r[1:0] != 2'b00);

    // exception vectors
    // interrupt tags line 1 only since line 2 is flushed behind it
    always_comb begin
        line1_excep_o           = '0;
        line1_excep_o[INT_BIT]  = int_i;
        line1_excep_o[ADEF_BIT] = line1_adef;

        line2_excep_o           = '0;
        line2_excep_o[ADEF_BIT] = line2_adef;
    end

    assign line1_excep_en_o = (int_i || line1_adef) && if_valid_r;
    assign line2_excep_en_o = line2_adef && if_valid_r;

    // outgoing lines
    assign line1_valid_o = if_valid_r && if_ready_go;
    assign line2_valid_o = if_valid_r && inst2_en_r && if_ready_go;  // second lookup hit

    assign line1_pc_o   = pc1_r;
    assign line2_pc_o   = pc2_r;
    assign line1_inst_o = inst1_r;
    assign line2_inst_o = inst2_r;

endmodule

// File: if_id_reg.sv
`timescale 1ns/10ps

module if_id_reg import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,

    // packet from IF
    input  logic   line1_valid_i,
    input  logic   line2_valid_i,
    input  pc_t    line1_pc_i,
    input  pc_t    line2_pc_i,
    input  inst_t  line1_inst_i,
    input  inst_t  line2_inst_i,
    input  logic   line1_excep_en_i,
    input  logic   line2_excep_en_i,
    input  excep_t line1_excep_i,
    input  excep_t line2_excep_i,
    output logic   id_allowin_o,     // to IF

    // decode side
    input  logic   id_allowin_i,     // consumer takes the packet
    output logic   out_valid1_o,
    output logic   out_valid2_o,
    output pc_t    out_pc1_o,
    output pc_t    out_pc2_o,
    output inst_t  out_inst1_o,
    output inst_t  out_inst2_o,
    output logic   out_excep_en1_o,
    output logic   out_excep_en2_o,
    output excep_t out_excep1_o,
    output excep_t out_excep2_o
);

    logic   valid1_r;
    logic   valid2_r;
    logic   id_ready_go;
    logic   if_to_id;                // packet handed over this cycle

    pc_t    pc1_r;
    pc_t    pc2_r;
    inst_t  inst1_r;
    inst_t  inst2_r;
    logic   excep_en1_r;
    logic   excep_en2_r;
    excep_t excep1_r;
    excep_t excep2_r;

    // register can always hand its packet on
    assign id_ready_go  = 1'b1;
    assign id_allowin_o = !valid1_r || (id_ready_go && id_allowin_i);
    assign if_to_id     = line1_valid_i && id_allowin_o;

    // valids follow the incoming packet whenever the slot opens
    // drops to zero when the old packet leaves with nothing behind it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid1_r <= 1'b0;
            valid2_r <= 1'b0;
        end else if (id_allowin_o) begin
            valid1_r <= line1_valid_i;
            valid2_r <= line2_valid_i;
        end
    end

    // packet payload
    always_ff @(posedge clk) begin
        if (if_to_id) begin
            pc1_r       <= line1_pc_i;
            pc2_r       <= line2_pc_i;
            inst1_r     <= line1_inst_i;
            inst2_r     <= line2_inst_i;
            excep_en1_r <= line1_excep_en_i;
            excep_en2_r <= line2_excep_en_i;
            excep1_r    <= line1_excep_i;
            excep2_r    <= line2_excep_i;
        end
    end

    assign out_valid1_o    = valid1_r && id_ready_go;
    assign out_valid2_o    = valid2_r && id_ready_go;
    assign out_pc1_o       = pc1_r;
    assign out_pc2_o       = pc2_r;
    assign out_inst1_o     = inst1_r;
    assign out_inst2_o     = inst2_r;
    assign out_excep_en1_o = excep_en1_r;
    assign out_excep_en2_o = excep_en2_r;
    assign out_excep1_o    = excep1_r;
    assign out_excep2_o    = excep2_r;

endmodule

// File: fetch_top.sv
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; #(
    parameter pc_t         RESET_PC  = '0,
    parameter int unsigned MEM_WORDS = 32
) (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   flush_i,
    input  pc_t    flush_pc_i,
    input  logic   int_i,
    input  logic   id_allowin_i,

    output logic   out_valid1_o,
    output logic   out_valid2_o,
    output pc_t    out_pc1_o,
    output pc_t    out_pc2_o,
    output inst_t  out_inst1_o,
    output inst_t  out_inst2_o,
    output logic   out_excep_en1_o,
    output logic   out_excep_en2_o,
    output excep_t out_excep1_o,
    output excep_t out_excep2_o
);

    // pre-IF <-> IF
    logic   pi_valid;
    pc_t    pi_pc1;
    pc_t    pi_pc2;
    logic   if_allowin;
    pc_t    next_base;

    // IF <-> memory
    pc_t    mem_pc;
    inst_t  mem_inst1;
    inst_t  mem_inst2;
    logic   mem_inst2_en;

    // IF -> ID register
    logic   line1_valid;
    logic   line2_valid;
    pc_t    line1_pc;
    pc_t    line2_pc;
    inst_t  line1_inst;
    inst_t  line2_inst;
    logic   line1_excep_en;
    logic   line2_excep_en;
    excep_t line1_excep;
    excep_t line2_excep;
    logic   id_allowin;                  // ID register back to IF

    pre_if_stage #(
        .RESET_PC    (RESET_PC)
    ) u_pre_if (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .flush_pc_i  (flush_pc_i),
        .if_allowin_i(if_allowin),
        .next_base_i (next_base),
        .pi_valid_o  (pi_valid),
        .pc1_o       (pi_pc1),
        .pc2_o       (pi_pc2)
    );

    inst_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_imem (
        .pc_i      (mem_pc),
        .inst1_o   (mem_inst1),
        .inst2_o   (mem_inst2),
        .inst2_en_o(mem_inst2_en)
    );

    if_stage u_if (
        .clk             (clk),
        .rst_i           (rst_i),
        .flush_i         (flush_i),
        .int_i           (int_i),
        .pi_valid_i      (pi_valid),
        .pc1_i           (pi_pc1),
        .pc2_i           (pi_pc2),
        .if_allowin_o    (if_allowin),
        .mem_pc_o        (mem_pc),
        .inst1_i         (mem_inst1),
        .inst2_i         (mem_inst2),
        .inst2_en_i      (mem_inst2_en),
        .next_base_o     (next_base),
        .id_allowin_i    (id_allowin),
        .line1_valid_o   (line1_valid),
        .line2_valid_o   (line2_valid),
        .line1_pc_o      (line1_pc),
        .line2_pc_o      (line2_pc),
        .line1_inst_o    (line1_inst),
        .line2_inst_o    (line2_inst),
        .line1_excep_en_o(line1_excep_en),
        .line2_excep_en_o(line2_excep_en),
        .line1_excep_o   (line1_excep),
        .line2_excep_o   (line2_excep)
    );

    if_id_reg u_if_id (
        .clk             (clk),
        .rst_i           (rst_i),
        .line1_valid_i   (line1_valid),
        .line2_valid_i   (line2_valid),
        .line1_pc_i      (line1_pc),
        .line2_pc_i      (line2_pc),
        .line1_inst_i    (line1_inst),
        .line2_inst_i    (line2_inst),
        .line1_excep_en_i(line1_excep_en),
        .line2_excep_en_i(line2_excep_en),
        .line1_excep_i   (line1_excep),
        .line2_excep_i   (line2_excep),
        .id_allowin_o    (id_allowin),
        .id_allowin_i    (id_allowin_i),
        .out_valid1_o    (out_valid1_o),
        .out_valid2_o    (out_valid2_o),
        .out_pc1_o       (out_pc1_o),
        .out_pc2_o       (out_pc2_o),
        .out_inst1_o     (out_inst1_o),
        .out_inst2_o     (out_inst2_o),
        .out_excep_en1_o (out_excep_en1_o),
        .out_excep_en2_o (out_excep_en2_o),
        .out_excep1_o    (out_excep1_o),
        .out_excep2_o    (out_excep2_o)
    );

endmodule

// File: fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    localparam pc_t         RESET_PC  = '0;
    localparam int unsigned MEM_WORDS = 32;
    localparam int          IDX_W     = $clog2(MEM_WORDS);
    localparam int          SEED      = 79;

    // packets requested per test
    localparam int N_SEQ   = 24;
    localparam int N_STALL = 40;
    localparam int N_FLUSH = 60;
    localparam int N_INT   = 24;
    localparam int TOTAL_PKTS     = N_SEQ + N_STALL + N_FLUSH + N_INT;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_PKTS;

    // old packets that may still drain after a flush, IF and ID hold one each
    localparam int MAX_STALE = 2;

    // expected contents of one packet
    typedef struct packed {
        logic   v2;          // line 2 present
        pc_t    pc2;
        inst_t  inst1;
        inst_t  inst2;
        logic   en1;
        logic   en2;
        excep_t x1;
        excep_t x2;
        pc_t    next_pc;     // start of the following packet
    } pair_t;

    logic   clk = 1'b0;
    logic   rst_i;
    logic   flush_i;
    pc_t    flush_pc_i;
    logic   int_i;
    logic   id_allowin_i;

    logic   out_valid1_o;
    logic   out_valid2_o;
    pc_t    out_pc1_o;
    pc_t    out_pc2_o;
    inst_t  out_inst1_o;
    inst_t  out_inst2_o;
    logic   out_excep_en1_o;
    logic   out_excep_en2_o;
    excep_t out_excep1_o;
    excep_t out_excep2_o;

    inst_t  model_mem [MEM_WORDS];   // own copy of the image

    string  test_name     = "reset";
    int     pkt_count     = 0;       // accepted packets so far
    int     err_count     = 0;
    int     flush_cnt     = 0;
    int     cycles        = 0;
    pc_t    exp_pc        = RESET_PC;
    logic   flush_pending = 1'b0;    // waiting for first packet at the target
    pc_t    pend_pc       = '0;
    int     stale_cnt     = 0;       // old-stream packets seen since the flush
    logic   id_int        = 1'b0;    // int level carried by the packet in ID

    fetch_top #(
        .RESET_PC       (RESET_PC),
        .MEM_WORDS      (MEM_WORDS)
    ) dut0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .flush_pc_i     (flush_pc_i),
        .int_i          (int_i),
        .id_allowin_i   (id_allowin_i),
        .out_valid1_o   (out_valid1_o),
        .out_valid2_o   (out_valid2_o),
        .out_pc1_o      (out_pc1_o),
        .out_pc2_o      (out_pc2_o),
        .out_inst1_o    (out_inst1_o),
        .out_inst2_o    (out_inst2_o),
        .out_excep_en1_o(out_excep_en1_o),
        .out_excep_en2_o(out_excep_en2_o),
        .out_excep1_o   (out_excep1_o),
        .out_excep2_o   (out_excep2_o)
    );

    initial begin
        $readmemh("prog.hex", model_mem);
    end

    initial begin
        forever #4 clk = ~clk;      // 8 ns period
    end

    // reference model of one fetch packet
    function automatic pair_t ref_pair(input pc_t pc, input logic irq);
        pair_t       r;
        int unsigned wi;
        logic        mis;
        r   = '0;
        wi  = pc >> 2;                          // word address
        mis = (pc[1:0] != 2'b00);
        r.v2    = (wi % LINE_WORDS) != (LINE_WORDS - 1);  // pair stays in one line
        r.pc2   = pc + pc_t'(INST_BYTES);
        r.inst1 = model_mem[IDX_W'(wi % MEM_WORDS)];
        r.inst2 = model_mem[IDX_W'((wi + 1) % MEM_WORDS)];
        r.x1[INT_BIT]  = irq;                   // only line 1 takes the interrupt
        r.x1[ADEF_BIT] = mis;
        r.en1          = irq || mis;
        r.x2[ADEF_BIT] = mis;                   // pc2 shares the low bits
        r.en2          = mis;
        r.next_pc = r.v2 ? pc + pc_t'(2 * INST_BYTES) : r.pc2;
        return r;
    endfunction

    task automatic report_fail(input string msg);
        err_count = err_count + 1;
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_pc(input string what, input pc_t exp_v, input pc_t act_v);
        if (act_v !== exp_v) begin
            report_fail($sformatf("Fail %s %s expected %h actual %h",
                                  test_name, what, exp_v, act_v));
        end
    endtask

    task automatic compare_inst(input string what, input inst_t exp_v, input inst_t act_v);
        if (act_v !== exp_v) begin
            report_fail($sformatf("Fail %s %s expected %h actual %h",
                                  test_name, what, exp_v, act_v));
        end
    endtask

    task automatic compare_excep(input string what, input excep_t exp_v, input excep_t act_v);
        if (act_v !== exp_v) begin
            report_fail($sformatf("Fail %s %s expected %h actual %h",
                                  test_name, what, exp_v, act_v));
        end
    endtask

    task automatic compare_bit(input string what, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            report_fail($sformatf("Fail %s %s expected %b actual %b",
                                  test_name, what, exp_v, act_v));
        end
    endtask

    // one packet leaves ID at the coming edge
    task automatic check_packet();
        pair_t exp_r;
        if (flush_pending && out_pc1_o == pend_pc) begin
            exp_pc        = pend_pc;        // switch to the new stream
            flush_pending = 1'b0;
        end else if (flush_pending) begin
            stale_cnt = stale_cnt + 1;      // old packet still draining
            if (stale_cnt > MAX_STALE) begin
                report_fail($sformatf("flush to %h not taken, %0d old packets in test %s",
                                      pend_pc, stale_cnt, test_name));
            end
        end
        exp_r = ref_pair(exp_pc, id_int);
        compare_pc("line1 pc", exp_pc, out_pc1_o);
        compare_inst("line1 inst", exp_r.inst1, out_inst1_o);
        compare_bit("line1 excep_en", exp_r.en1, out_excep_en1_o);
        compare_excep("line1 excep", exp_r.x1, out_excep1_o);
        compare_bit("line2 valid", exp_r.v2, out_valid2_o);
        if (exp_r.v2) begin
            compare_pc("line2 pc", exp_r.pc2, out_pc2_o);
            compare_inst("line2 inst", exp_r.inst2, out_inst2_o);
            compare_bit("line2 excep_en", exp_r.en2, out_excep_en2_o);
            compare_excep("line2 excep", exp_r.x2, out_excep2_o);
        end
        exp_pc    = exp_r.next_pc;
        pkt_count = pkt_count + 1;
    endtask

    // compare process
    initial begin
        forever begin
            @(negedge clk);
            #1;                              // inputs for the next edge settled
            if (!rst_i) begin
                if (out_valid2_o && !out_valid1_o) begin
                    report_fail($sformatf("line 2 valid without line 1 in test %s",
                                          test_name));
                end
                if (out_valid1_o && id_allowin_i) begin
                    check_packet();
                end
                if (flush_i) begin
                    flush_pending = 1'b1;    // old packet in ID may still come out
                    pend_pc       = flush_pc_i;
                    stale_cnt     = 0;
                end
                if (!out_valid1_o || id_allowin_i) begin
                    id_int = int_i;          // level taken by whatever enters ID
                end
            end
        end
    end

    // drive one test until enough packets came out
    task automatic run_test(input string name, input int n_pkts, input logic rand_allow,
                            input logic do_flush, input int int_mode);
        int  target;
        pc_t tgt;
        target    = pkt_count + n_pkts;
        test_name = name;
        while (pkt_count < target) begin
            @(negedge clk);
            id_allowin_i = rand_allow ? (($urandom % 4) != 0) : 1'b1;
            flush_i      = 1'b0;
            case (int_mode)
                0:       int_i = 1'b0;
                1:       int_i = 1'b1;                   // held steady
                default: int_i = (($urandom % 5) == 0);  // short pulses
            endcase
            if (do_flush && !flush_pending && (($urandom % 6) == 0)) begin
                flush_cnt = flush_cnt + 1;
                tgt       = pc_t'(flush_cnt) << 16;      // fresh region per flush
                tgt       = tgt + pc_t'(($urandom % 64) * 4);
                if ((flush_cnt % 2) == 0) begin
                    tgt = tgt + pc_t'(1 + ($urandom % 3));  // misaligned target
                end
                flush_i    = 1'b1;
                flush_pc_i = tgt;
            end
        end
    endtask

    // stimulus
    initial begin
        void'($urandom(SEED));
        rst_i        = 1'b1;
        flush_i      = 1'b0;
        flush_pc_i   = '0;
        int_i        = 1'b0;
        id_allowin_i = 1'b1;
        repeat (3) @(negedge clk);
        compare_bit("valid1 in reset", 1'b0, out_valid1_o);
        compare_bit("valid2 in reset", 1'b0, out_valid2_o);
        rst_i = 1'b0;

        run_test("sequential", N_SEQ, 1'b0, 1'b0, 0);
        run_test("backpressure", N_STALL, 1'b1, 1'b0, 0);
        run_test("flush", N_FLUSH, 1'b1, 1'b1, 2);
        run_test("interrupt", N_INT, 1'b1, 1'b0, 1);

        @(negedge clk);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                report_fail($sformatf("run timed out after %0d cycles in test %s",
                                      cycles, test_name));
            end
        end
    end

endmodule

// File: prog.hex
// one 32-bit instruction word per line starting at word address 0
02000c1c
1c00000c
28c0018c
29800184
00150004
4c000020
0280040c
15fffffe
03400000
50000c00
02bffc63
5ffff8a0
0015008d
1400002e
29c0018d
0c3fe123
8b1df00d
13579bdf
2468ace0
0f1e2d3c
4b5a6978
87654321
fedcba98
76543210
a5a5c3c3
5a5a3c3c
00ff00ff
ff00ff00
11223344
55667788
99aabbcc
ddeeff01

// File: sim.f
fetch_pkg.sv
pre_if_stage.sv
inst_mem.sv
if_stage.sv
if_id_reg.sv
fetch_top.sv
fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fetch front end with its testbench, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/10ps --top-module fetch_tb -f sim.f \
    -o fetch_sim > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1 \
    || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
